// ==== sim/exec_patterns.txt ====
# opcode a b expected, all hex; opcode 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLL 6 SRL 7 SLT 8 MUL
# one operation per line, expected value is the low word of the result
0 00000005 00000003 00000008
0 ffffffff 00000001 00000000
1 00000010 00000003 0000000d
1 00000000 00000001 ffffffff
2 f0f0f0f0 ff00ff00 f000f000
3 f0f0f0f0 0f0f0000 fffff0f0
4 aaaaaaaa ffff0000 5555aaaa
5 00000001 0000001f 80000000
5 12345678 00000024 23456780
6 80000000 0000001f 00000001
6 f0000000 00000004 0f000000
7 ffffffff 00000001 00000001
7 00000001 ffffffff 00000000
7 80000000 7fffffff 00000001
7 7fffffff 80000000 00000000
7 00000005 00000005 00000000
8 ffffffff ffffffff 00000001
0 00000001 00000001 00000002
2 0000ffff 000000ff 000000ff
4 00000003 00000001 00000002
8 00000007 00000006 0000002a
8 12345678 00000000 00000000
8 00000000 ffffffff 00000000
8 00010000 00010000 00000000
8 0000ffff 0000ffff fffe0001
8 deadbeef 00000001 deadbeef
1 7fffffff ffffffff 80000000
8 00000003 80000000 80000000
0 00000010 00000020 00000030
3 00000000 00000000 00000000

// ==== all.f ====
+incdir+source
source/exec_pkg.sv
source/exec_alu.sv
source/exec_lane.sv
source/exec_dispatch.sv
source/exec_retire.sv
source/exec_unit.sv
sim/exec_unit_assert.sv
sim/tb_exec_unit.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_exec_unit

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): all.f $(wildcard source/*.sv source/*.svh sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_exec_unit -o Vtb_exec_unit

# An abnormal exit counts as a failure
run: $(BIN)
	$(BIN) > sim.log 2>&1 || echo "Regression failed" >> sim.log
	cat sim.log
	! grep -q "Regression failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module tb_exec_unit;

  import exec_pkg::*;

  logic        bus;
  logic        rst;
  logic        in_valid;
  opcode_t     in_op;
  word_t       in_a;
  word_t       in_b;
  tag_t        in_tag;
  logic        in_credit;
  logic        out_valid;
  word_t       out_result;
  tag_t        out_tag;
  logic        out_credit;

  // Pattern table
  opcode_t     pat_op[$];
  word_t       pat_a[$];
  word_t       pat_b[$];
  word_t       pat_exp[$];
  // Scoreboard, issue order
  word_t       exp_res_q[$];
  tag_t        exp_tag_q[$];
  // Cycle at which each consumer slot frees up
  int          due_q[$];

  int          checks;
  int          val_errs;
  int          other_errs;
  int          cycle;
  int          limit;
  int          npat;
  int          issued;
  int          retired;
  int          credit_pulses;
  int          valid_cnt;
  int          returned;
  int          prod_credits;
  int          hold_from;
  tag_t        next_tag;

  exec_unit DUT (
    .bus       (bus),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_tag    (in_tag),
    .in_credit (in_credit),
    .out_valid (out_valid),
    .out_result(out_result),
    .out_tag   (out_tag),
    .out_credit(out_credit)
  );

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;
  end

  always @(posedge bus) begin
    cycle <= cycle + 1;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      val_errs++;
      $display("Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    other_errs++;
    $display("%s", what);
  endtask

  task automatic finish_run();
    $display("Checks %0d, value errors %0d, other errors %0d", checks, val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_e;
    fd = $fopen("sim/exec_patterns.txt", "r");
    if (fd == 0) begin
      report_problem("Could not open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      // Skip the column notes
      if (line.len() > 0 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_e);
        if (n == 4) begin
          pat_op.push_back(opcode_t'(f_op));
          pat_a.push_back(f_a);
          pat_b.push_back(f_b);
          pat_exp.push_back(f_e);
        end
      end
    end
    $fclose(fd);
    npat = pat_op.size();
    if (npat == 0) report_problem("No patterns were read");
  endtask

  ////////////////////
  // Per-cycle models
  ////////////////////
  task automatic sample_outputs();
    if (in_credit) begin
      credit_pulses++;
      prod_credits++;
    end
    if (prod_credits > `EXEC_LANES) begin
      report_problem("Producer got back more credits than there are lanes");
    end
    if (out_valid) begin
      valid_cnt++;
      // Consumer frees the slot 0 to 5 cycles later
      due_q.push_back(cycle + int'($urandom % 6));
      if (exp_res_q.size() == 0) begin
        report_problem("A result arrived with no operation outstanding");
      end else begin
        check("out_result", out_result, exp_res_q.pop_front());
        check("out_tag", out_tag, exp_tag_q.pop_front());
        retired++;
      end
    end
    // Results bounded by buffer depth plus returned slots
    if (valid_cnt > `EXEC_OUT_CREDITS + returned) begin
      report_problem("More results sent than the consumer had room for");
    end
  endtask

  task automatic drive_consumer();
    logic holding;
    holding = (hold_from >= 0) && (cycle < hold_from + 20);
    out_credit = 1'b0;
    if (!holding && due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      out_credit = 1'b1;
      returned++;
    end
  endtask

  task automatic drive_producer();
    in_valid = 1'b0;
    if (issued < npat && prod_credits > 0) begin
      in_valid = 1'b1;
      in_op    = pat_op[issued];
      in_a     = pat_a[issued];
      in_b     = pat_b[issued];
      in_tag   = next_tag;
      exp_res_q.push_back(pat_exp[issued]);
      exp_tag_q.push_back(next_tag);
      next_tag++;
      issued++;
      prod_credits--;
      if (issued - retired > `EXEC_LANES) begin
        report_problem("More operations outstanding than there are lanes");
      end
      // Consumer withholds credits from halfway on
      if (issued == npat / 2) hold_from = cycle;
    end
  endtask

  initial begin : watchdog
    wait (limit != 0);
    while (cycle < limit) @(posedge bus);
    report_problem($sformatf("Timeout, the run did not finish within %0d cycles", limit));
    finish_run();
  end

  initial begin
    void'($urandom(29183));
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_op        = '0;
    in_a         = '0;
    in_b         = '0;
    in_tag       = '0;
    out_credit   = 1'b0;
    next_tag     = '0;
    hold_from    = -1;
    prod_credits = `EXEC_LANES;
    load_patterns();
    limit = 40 * npat + 100;
    repeat (5) @(negedge bus);
    rst = 1'b0;
    // Quiet outputs before the first operation
    repeat (3) begin
      @(negedge bus);
      check("out_valid", out_valid, 1'b0);
      check("in_credit", in_credit, 1'b0);
    end
    while (retired < npat) begin
      @(negedge bus);
      sample_outputs();
      drive_consumer();
      drive_producer();
    end
    // One credit back for every operation issued
    check("in_credit count", credit_pulses, issued);
    if (exp_res_q.size() != 0) report_problem("Some results were lost");
    finish_run();
  end

endmodule : tb_exec_unit

`default_nettype wire

// ==== sim/exec_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_unit_assert (
  input wire                   bus,
  input wire                   rst,
  input wire                   in_valid,
  input wire                   out_valid,
  input wire                   out_credit,
  input wire                   in_credit,
  input wire [`EXEC_LANES-1:0] lane_done,
  input wire [`EXEC_LANES-1:0] lane_pop
);

  import exec_pkg::*;

  // Operations accepted and not yet credited back
  typedef logic [$clog2(`EXEC_LANES+1)-1:0] outst_t;

  // Shadow of the downstream credit count
  credit_t cred_q;
  outst_t  outst_q;

  always_ff @(posedge bus) begin
    if (rst) begin
      cred_q  <= credit_t'(`EXEC_OUT_CREDITS);
      outst_q <= '0;
    end else begin
      cred_q  <= cred_q + credit_t'(out_credit) - credit_t'(out_valid);
      outst_q <= outst_q + outst_t'(in_valid) - outst_t'(in_credit);
    end
  end

  ////////////////////
  // Credit and order rules
  ////////////////////
  a_out_credit: assert property (@(posedge bus) disable iff (rst) out_valid |-> (cred_q != '0))
    else $error("out_valid fired with no downstream credit");

  // A popped lane leaves the done state on the next cycle
  a_pop_done: assert property (@(posedge bus) disable iff (rst)
      (lane_pop != '0) |=> ((lane_done & $past(lane_pop)) == '0))
    else $error("lane still done after its pop");

  // Input credit only returned for an accepted operation
  a_in_credit: assert property (@(posedge bus) disable iff (rst)
      in_credit |-> (outst_q != '0))
    else $error("in_credit returned with no operation outstanding");

endmodule : exec_unit_assert

bind exec_unit exec_unit_assert u_assert (
  .bus       (bus),
  .rst       (rst),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_credit(out_credit),
  .in_credit (in_credit),
  .lane_done (lane_done),
  .lane_pop  (lane_pop)
);

`default_nettype wire

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_unit (
  input  wire                    bus,
  input  wire                    rst,
  input  wire                    in_valid,
  input  wire exec_pkg::opcode_t in_op,
  input  wire exec_pkg::word_t   in_a,
  input  wire exec_pkg::word_t   in_b,
  input  wire exec_pkg::tag_t    in_tag,
  output logic                   in_credit,
  output logic                   out_valid,
  output exec_pkg::word_t        out_result,
  output exec_pkg::tag_t         out_tag,
  input  wire                    out_credit
);

  import exec_pkg::*;

  // Dispatch to lanes
  logic [`EXEC_LANES-1:0] lane_start;
  opcode_t                lane_op;
  word_t                  lane_a;
  word_t                  lane_b;
  tag_t                   lane_tag;
  // Lanes to retire
  logic [`EXEC_LANES-1:0] lane_done;
  word_t                  lane_result  [`EXEC_LANES];
  tag_t                   lane_res_tag [`EXEC_LANES];
  logic [`EXEC_LANES-1:0] lane_pop;

  exec_dispatch u_dispatch (
    .bus       (bus),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .in_tag    (in_tag),
    .lane_start(lane_start),
    .lane_op   (lane_op),
    .lane_a    (lane_a),
    .lane_b    (lane_b),
    .lane_tag  (lane_tag)
  );

  ////////////////////
  // Execute lanes
  ////////////////////
  for (genvar i = 0; i < `EXEC_LANES; i++) begin : g_lane
    exec_lane u_lane (
      .bus    (bus),
      .rst    (rst),
      .start  (lane_start[i]),
      .op     (lane_op),
      .a      (lane_a),
      .b      (lane_b),
      .tag    (lane_tag),
      .pop    (lane_pop[i]),
      .done   (lane_done[i]),
      .result (lane_result[i]),
      .res_tag(lane_res_tag[i])
    );
  end

  // In-order drain
  exec_retire u_retire (
    .bus        (bus),
    .rst        (rst),
    .lane_done  (lane_done),
    .lane_result(lane_result),
    .lane_tag   (lane_res_tag),
    .out_credit (out_credit),
    .lane_pop   (lane_pop),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_tag    (out_tag),
    .in_credit  (in_credit)
  );

endmodule : exec_unit

`default_nettype wire

// ==== source/exec_retire.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_retire (
  input  wire                    bus,
  input  wire                    rst,
  input  wire [`EXEC_LANES-1:0]  lane_done,
  input  wire exec_pkg::word_t   lane_result [`EXEC_LANES],
  input  wire exec_pkg::tag_t    lane_tag    [`EXEC_LANES],
  input  wire                    out_credit,
  output logic [`EXEC_LANES-1:0] lane_pop,
  output logic                   out_valid,
  output exec_pkg::word_t        out_result,
  output exec_pkg::tag_t         out_tag,
  output logic                   in_credit
);

  import exec_pkg::*;

  // Oldest lane, follows dispatch order
  lane_idx_t ptr_q;
  // Free downstream slots
  credit_t   cred_q;
  logic      emit;

  // Retire when the oldest lane is done and a slot is free
  assign emit = lane_done[ptr_q] && (cred_q != '0);

  ////////////////////
  // Order and credits
  ////////////////////
  always_ff @(posedge bus) begin
    if (rst) begin
      ptr_q  <= '0;
      cred_q <= credit_t'(`EXEC_OUT_CREDITS);
    end else begin
      // Return and spend may land in the same cycle
      cred_q <= cred_q + credit_t'(out_credit) - credit_t'(emit);
      if (emit) begin
        ptr_q <= (ptr_q == lane_idx_t'(`EXEC_LANES-1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  // Pop the retired lane
  always_comb begin
    lane_pop        = '0;
    lane_pop[ptr_q] = emit;
  end

  assign out_valid  = emit;
  assign out_result = lane_result[ptr_q];
  assign out_tag    = lane_tag[ptr_q];
  // One input credit back per retired operation
  assign in_credit  = emit;

endmodule : exec_retire

`default_nettype wire

// ==== source/exec_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_dispatch (
  input  wire                    bus,
  input  wire                    rst,
  input  wire                    in_valid,
  input  wire exec_pkg::opcode_t in_op,
  input  wire exec_pkg::word_t   in_a,
  input  wire exec_pkg::word_t   in_b,
  input  wire exec_pkg::tag_t    in_tag,
  output logic [`EXEC_LANES-1:0] lane_start,
  output exec_pkg::opcode_t      lane_op,
  output exec_pkg::word_t        lane_a,
  output exec_pkg::word_t        lane_b,
  output exec_pkg::tag_t         lane_tag
);

  import exec_pkg::*;

  // Registered operation waiting for its lane
  logic      pend_q;
  lane_idx_t ptr_q;
  opcode_t   op_q;
  word_t     a_q;
  word_t     b_q;
  tag_t      tag_q;

  ////////////////////
  // Input register
  ////////////////////
  always_ff @(posedge bus) begin
    if (rst) begin
      pend_q <= 1'b0;
      ptr_q  <= '0;
    end else begin
      pend_q <= in_valid;
      // Next lane in round-robin order, wraps at the last lane
      if (pend_q) begin
        ptr_q <= (ptr_q == lane_idx_t'(`EXEC_LANES-1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge bus) begin
    if (in_valid) begin
      op_q  <= in_op;
      a_q   <= in_a;
      b_q   <= in_b;
      tag_q <= in_tag;
    end
  end

  // One-hot start, target lane is free by the credit rule
  always_comb begin
    lane_start        = '0;
    lane_start[ptr_q] = pend_q;
  end

  // Fields shared by all lanes
  assign lane_op  = op_q;
  assign lane_a   = a_q;
  assign lane_b   = b_q;
  assign lane_tag = tag_q;

endmodule : exec_dispatch

`default_nettype wire

// ==== source/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_lane (
  input  wire                    bus,
  input  wire                    rst,
  input  wire                    start,
  input  wire exec_pkg::opcode_t op,
  input  wire exec_pkg::word_t   a,
  input  wire exec_pkg::word_t   b,
  input  wire exec_pkg::tag_t    tag,
  input  wire                    pop,
  output logic                   done,
  output exec_pkg::word_t        result,
  output exec_pkg::tag_t         res_tag
);

  import exec_pkg::*;

  lane_state_e state_q;
  // ALU result, or the running MUL sum
  word_t       acc_q;
  word_t       acc_next;
  word_t       mcand_q;
  word_t       mplier_q;
  tag_t        tag_q;
  word_t       alu_res;
  logic        take;
  logic        is_mul;
  logic        mul_last;

  exec_alu u_alu (
    .op    (op),
    .a     (a),
    .b     (b),
    .result(alu_res)
  );

  // Operation accepted only while idle
  assign take     = (state_q == LANE_IDLE) && start;
  assign is_mul   = (op == `EXEC_OP_MUL);
  // Add shifted multiplicand on a set multiplier bit
  assign acc_next = mplier_q[0] ? acc_q + mcand_q : acc_q;
  // Early exit, no set bits left above this one
  assign mul_last = (mplier_q[`EXEC_WORD_W-1:1] == '0);

  ////////////////////
  // Lane FSM
  ////////////////////
  always_ff @(posedge bus) begin
    if (rst) begin
      state_q <= LANE_IDLE;
    end else begin
      case (state_q)
        LANE_IDLE: begin
          if (start) begin
            state_q <= is_mul ? LANE_MUL : LANE_DONE;
          end
        end
        LANE_MUL: begin
          if (mul_last) begin
            state_q <= LANE_DONE;
          end
        end
        // Result held until retire pops it
        LANE_DONE: begin
          if (pop) begin
            state_q <= LANE_IDLE;
          end
        end
        default: state_q <= LANE_IDLE;
      endcase
    end
  end

  // Payload and multiplier datapath
  always_ff @(posedge bus) begin
    if (take) begin
      tag_q    <= tag;
      mcand_q  <= a;
      mplier_q <= b;
      acc_q    <= is_mul ? '0 : alu_res;
    end else if (state_q == LANE_MUL) begin
      // Low word of the product only
      acc_q    <= acc_next;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign done    = (state_q == LANE_DONE);
  assign result  = acc_q;
  assign res_tag = tag_q;

endmodule : exec_lane

`default_nettype wire

// ==== source/exec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_defs.svh"

module exec_alu (
  input  wire exec_pkg::opcode_t op,
  input  wire exec_pkg::word_t   a,
  input  wire exec_pkg::word_t   b,
  output exec_pkg::word_t        result
);

  // Shift amount, low bits of b only
  logic [$clog2(`EXEC_WORD_W)-1:0] shamt;
  // Signed compare flag for SLT
  logic                            lt;

  assign shamt = b[$clog2(`EXEC_WORD_W)-1:0];
  assign lt    = $signed(a) < $signed(b);

  ////////////////////
  // Opcode select
  ////////////////////
  always_comb begin
    case (op)
      `EXEC_OP_ADD: result = a + b;
      `EXEC_OP_SUB: result = a - b;
      `EXEC_OP_AND: result = a & b;
      `EXEC_OP_OR:  result = a | b;
      `EXEC_OP_XOR: result = a ^ b;
      // Logical shifts, zero fill
      `EXEC_OP_SLL: result = a << shamt;
      `EXEC_OP_SRL: result = a >> shamt;
      // Compare result widened to a full word
      `EXEC_OP_SLT: result = {{(`EXEC_WORD_W-1){1'b0}}, lt};
      // MUL runs in the lane, nothing to do here
      default:      result = '0;
    endcase
  end

endmodule : exec_alu

`default_nettype wire

// ==== source/exec_pkg.sv ====
`default_nettype none

`include "exec_defs.svh"

package exec_pkg;

  // Data path vectors
  typedef logic [`EXEC_WORD_W-1:0] word_t;
  typedef logic [`EXEC_TAG_W-1:0]  tag_t;
  typedef logic [`EXEC_OP_W-1:0]   opcode_t;

  // Selects one execute slot
  typedef logic [$clog2(`EXEC_LANES)-1:0] lane_idx_t;

  // Holds 0 up to the full downstream depth
  typedef logic [$clog2(`EXEC_OUT_CREDITS+1)-1:0] credit_t;

  // Lane FSM
  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_MUL,
    LANE_DONE
  } lane_state_e;

endpackage : exec_pkg

`default_nettype wire

// ==== source/exec_defs.svh ====
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Cluster sizing
`define EXEC_LANES       4
`define EXEC_WORD_W      32
`define EXEC_TAG_W       4
`define EXEC_OP_W        4
// Downstream buffer slots
`define EXEC_OUT_CREDITS 2

// Opcode encodings
`define EXEC_OP_ADD 4'h0
`define EXEC_OP_SUB 4'h1
`define EXEC_OP_AND 4'h2
`define EXEC_OP_OR  4'h3
`define EXEC_OP_XOR 4'h4
`define EXEC_OP_SLL 4'h5
`define EXEC_OP_SRL 4'h6
`define EXEC_OP_SLT 4'h7
`define EXEC_OP_MUL 4'h8

`endif
